/* sim.f */
ex_isa_pkg.sv
ex_unit_pkg.sv
ex_decode.sv
ex_alu.sv
ex_mult.sv
ex_result.sv
ex_block.sv
tb_clk_gen.sv
ex_block_asserts.sv
ex_block_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = ex_block_tb
FILELIST  = sim.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* ex_block_tb.sv */
////////////////////////////////////////
// Directed testbench for ex_block
// Reference models, compare tasks, LCG,
// cycle watchdog and the test sequence
////////////////////////////////////////

`timescale 1ns/10ps

module ex_block_tb;

  import ex_isa_pkg::*;
  import ex_unit_pkg::*;

  localparam int TIMEOUT_CYCLES = 6000;
  localparam int RESET_CYCLES   = 10;
  localparam int N_CORNER       = 6;
  localparam int N_PAIRS        = N_CORNER * N_CORNER + 10;

  logic    clk;
  logic    rst;
  logic    en;
  ex_req_t req;
  logic    lsu_ready;
  ex_rsp_t rsp;
  logic    ex_ready;

  int          cycle_count = 0;
  logic [31:0] rand_state;

  // Edge operands of zero, one, sign boundaries, all ones and a pattern
  ex_word_t corner_vals [N_CORNER] = '{32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff,
                                       32'h8000_0000, 32'hffff_ffff, 32'ha5a5_a5a4};
  ex_op_e alu_ops [8]  = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA};
  ex_op_e cmp_ops [8]  = '{OP_SLT, OP_SLTU, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
  ex_op_e mult_ops [4] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};

  tb_clk_gen u_clk_gen (.clk_o(clk));

  ex_block DUT (
    .clk         (clk),
    .rst_i       (rst),
    .en_i        (en),
    .req_i       (req),
    .lsu_ready_i (lsu_ready),
    .rsp_o       (rsp),
    .ex_ready_o  (ex_ready)
  );

  ////////////////////////////////////////
  // Stimulus and reference models
  ////////////////////////////////////////

  // Numerical Recipes LCG constants
  function automatic ex_word_t next_random();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic logic compare_model(input ex_op_e op, input ex_word_t a, input ex_word_t b);
    case (op)
      OP_SLT, OP_BLT:   return $signed(a) < $signed(b);
      OP_SLTU, OP_BLTU: return a < b;
      OP_BEQ:           return a == b;
      OP_BNE:           return a != b;
      OP_BGE:           return $signed(a) >= $signed(b);
      OP_BGEU:          return a >= b;
      default:          return 1'b0;
    endcase
  endfunction

  function automatic ex_word_t alu_model(input ex_op_e op, input ex_word_t a, input ex_word_t b);
    case (op)
      OP_ADD:          return a + b;
      OP_SUB:          return a - b;
      OP_AND:          return a & b;
      OP_OR:           return a | b;
      OP_XOR:          return a ^ b;
      OP_SLL:          return a << b[4:0];
      OP_SRL:          return a >> b[4:0];
      OP_SRA:          return ex_word_t'($signed(a) >>> b[4:0]);
      OP_SLT, OP_SLTU: return {{(XLEN-1){1'b0}}, compare_model(op, a, b)};
      default:         return '0;
    endcase
  endfunction

  // Word select from the full 64-bit product of the extended operands
  function automatic ex_word_t mult_model(input ex_op_e op, input ex_word_t a, input ex_word_t b);
    logic              a_sgn;
    logic              b_sgn;
    logic [2*XLEN-1:0] a_ext;
    logic [2*XLEN-1:0] b_ext;
    logic [2*XLEN-1:0] product;
    a_sgn   = a[XLEN-1] & (op == OP_MULH || op == OP_MULHSU);
    b_sgn   = b[XLEN-1] & (op == OP_MULH);
    a_ext   = {{XLEN{a_sgn}}, a};
    b_ext   = {{XLEN{b_sgn}}, b};
    product = a_ext * b_ext;
    return (op == OP_MUL) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];
  endfunction

  // Corner pairs come before random pairs with some equal ones
  task automatic pick_operands(input int i, output ex_word_t a, output ex_word_t b);
    if (i < N_CORNER * N_CORNER) begin
      a = corner_vals[i / N_CORNER];
      b = corner_vals[i % N_CORNER];
    end else begin
      a = next_random();
      b = (i % 4 == 0) ? a : next_random();
    end
  endtask

  task automatic drive_req(input ex_op_e op, input ex_word_t a, input ex_word_t b);
    @(posedge clk);
    #1;
    en            = 1'b1;
    req.op        = op;
    req.operand_a = a;
    req.operand_b = b;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #1;
    en = 1'b0;
  endtask

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "execute stage run stopped");
  endtask

  task automatic check_word(input string name, input ex_word_t expected, input ex_word_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("mismatch %s: expected %b, actual %b", name, expected, actual));
    end
  endtask

  task automatic check_ready_cycles(input string name, input int expected, input int actual);
    if (actual != expected) begin
      report_failure($sformatf("mismatch %s: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  // Present one multiply, count the stall cycles, check the product
  task automatic run_mult(input string name, input ex_op_e op, input ex_word_t a,
                          input ex_word_t b);
    int low_cycles;
    low_cycles = 0;
    drive_req(op, a, b);
    @(negedge clk);
    while (!ex_ready) begin
      low_cycles++;
      @(negedge clk);
    end
    check_ready_cycles({name, " stall"}, MULT_CYCLES, low_cycles);
    check_word(name, mult_model(op, a, b), rsp.wdata);
    check_flag({name, " branch"}, 1'b0, rsp.branch_decision);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_alu_ops();
    ex_word_t a;
    ex_word_t b;
    string    name;
    foreach (alu_ops[k]) begin
      name = $sformatf("test_alu_ops %s", alu_ops[k].name());
      for (int i = 0; i < N_PAIRS; i++) begin
        pick_operands(i, a, b);
        drive_req(alu_ops[k], a, b);
        @(negedge clk);
        check_flag({name, " ready"}, 1'b1, ex_ready);
        check_word(name, alu_model(alu_ops[k], a, b), rsp.wdata);
        check_flag({name, " branch"}, 1'b0, rsp.branch_decision);
        if (alu_ops[k] == OP_ADD) check_word({name, " adder"}, a + b, rsp.adder_result);
        if (alu_ops[k] == OP_SUB) check_word({name, " adder"}, a - b, rsp.adder_result);
      end
    end
  endtask

  task automatic test_compare();
    ex_word_t a;
    ex_word_t b;
    string    name;
    foreach (cmp_ops[k]) begin
      name = $sformatf("test_compare %s", cmp_ops[k].name());
      for (int i = 0; i < N_PAIRS; i++) begin
        pick_operands(i, a, b);
        drive_req(cmp_ops[k], a, b);
        @(negedge clk);
        check_flag({name, " ready"}, 1'b1, ex_ready);
        // Set-less-than writes back while branches only decide
        if (cmp_ops[k] == OP_SLT || cmp_ops[k] == OP_SLTU) begin
          check_word(name, alu_model(cmp_ops[k], a, b), rsp.wdata);
        end else begin
          check_flag(name, compare_model(cmp_ops[k], a, b), rsp.branch_decision);
        end
      end
    end
  endtask

  task automatic test_mult();
    ex_word_t a;
    ex_word_t b;
    foreach (mult_ops[k]) begin
      for (int i = 0; i < N_PAIRS; i++) begin
        pick_operands(i, a, b);
        run_mult($sformatf("test_mult %s", mult_ops[k].name()), mult_ops[k], a, b);
        idle_cycle();
      end
    end
  endtask

  // Next multiply goes out on the edge right after ready
  task automatic test_back_to_back_mult();
    ex_word_t sel;
    ex_op_e   op;
    for (int i = 0; i < 40; i++) begin
      sel = next_random();
      op  = mult_ops[sel[1:0]];
      run_mult($sformatf("test_back_to_back_mult %0d %s", i, op.name()), op,
               next_random(), next_random());
    end
    idle_cycle();
  endtask

  task automatic test_lsu_stall();
    ex_word_t a;
    ex_word_t b;
    ex_word_t wait_sel;
    int       wait_cycles;
    for (int i = 0; i < 20; i++) begin
      a           = next_random();
      b           = next_random();
      wait_sel    = next_random();
      wait_cycles = int'(wait_sel[2:0]);
      drive_req(OP_LSU_ADDR, a, b);
      lsu_ready = (wait_cycles == 0);
      for (int c = 0; c < wait_cycles; c++) begin
        @(negedge clk);
        check_flag("test_lsu_stall ready low", 1'b0, ex_ready);
        check_word("test_lsu_stall adder", a + b, rsp.adder_result);
        @(posedge clk);
        #1;
        if (c == wait_cycles - 1) lsu_ready = 1'b1;
      end
      @(negedge clk);
      check_flag("test_lsu_stall ready high", 1'b1, ex_ready);
      check_word("test_lsu_stall adder", a + b, rsp.adder_result);
      check_flag("test_lsu_stall branch", 1'b0, rsp.branch_decision);
    end
    idle_cycle();
    lsu_ready = 1'b0;
  endtask

  task automatic test_reset_mid_mult();
    drive_req(OP_MULH, next_random(), next_random());
    repeat (2) begin
      @(negedge clk);
      check_flag("test_reset_mid_mult busy", 1'b0, ex_ready);
    end
    // One reset cycle while the multiplier sits in PP_HL
    // Without it the next request would meet DONE and see ready at once
    @(posedge clk);
    #1;
    rst = 1'b1;
    en  = 1'b0;
    @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_flag("test_reset_mid_mult ready after reset", 1'b1, ex_ready);
    run_mult("test_reset_mid_mult", OP_MULHSU, next_random(), next_random());
    idle_cycle();
  endtask

  ////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("timeout: run did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
    end
  end

  initial begin
    rand_state = 32'hb2bce42c;
    rst        = 1'b1;
    en         = 1'b0;
    req        = '0;
    lsu_ready  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    test_alu_ops();
    test_compare();
    test_mult();
    test_back_to_back_mult();
    test_lsu_stall();
    test_reset_mid_mult();
    @(negedge clk);
    $display("TEST PASS");
    $finish;
  end

endmodule

/* ex_block_asserts.sv */
////////////////////////////////////////
// Protocol checks for the execute stage
// Request hold, idle ready, done pulse,
// bind onto ex_block
////////////////////////////////////////

`timescale 1ns/10ps

module ex_block_asserts (
  input logic                clk,
  input logic                rst_i,
  input logic                en_i,
  input ex_isa_pkg::ex_req_t req_i,
  input logic                ex_ready_i,
  input logic                mult_done_i
);

  // Source holds the request until the stage is ready
  req_held: assert property (@(posedge clk) disable iff (rst_i)
    (en_i && !ex_ready_i) |=> (en_i && $stable(req_i)))
    else $error("request changed or dropped while the stage was stalled");

  // An idle stage always reports ready
  idle_ready: assert property (@(posedge clk) disable iff (rst_i)
    !en_i |-> ex_ready_i)
    else $error("stage not ready while no request was present");

  // Multiplier done is a single-cycle pulse
  done_pulse: assert property (@(posedge clk) disable iff (rst_i)
    mult_done_i |=> !mult_done_i)
    else $error("multiplier done stayed high for more than one cycle");

endmodule

bind ex_block ex_block_asserts u_asserts (
  .clk         (clk),
  .rst_i       (rst_i),
  .en_i        (en_i),
  .req_i       (req_i),
  .ex_ready_i  (ex_ready_o),
  .mult_done_i (mult_done)
);

/* tb_clk_gen.sv */
////////////////////////////////////////
// Testbench clock source, 8 ns period
////////////////////////////////////////

`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o
);

  // Half of the 8 ns period
  localparam int HALF_PERIOD_NS = 4;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end
  end

endmodule

/* ex_block.sv */
////////////////////////////////////////
// Execute stage top level
// Decoder, ALU, multiplier and result
// select between decode and write-back
////////////////////////////////////////

`timescale 1ns/10ps

module ex_block (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                en_i,
  input  ex_isa_pkg::ex_req_t req_i,
  input  logic                lsu_ready_i,
  output ex_isa_pkg::ex_rsp_t rsp_o,
  output logic                ex_ready_o
);

  import ex_isa_pkg::*;
  import ex_unit_pkg::*;

  alu_ctrl_t  alu_ctrl;
  mult_ctrl_t mult_ctrl;
  ex_unit_e   unit;

  ex_word_t   alu_result;
  ex_word_t   adder_result;
  logic       cmp_result;
  ex_word_t   mult_result;
  logic       mult_done;
  ex_word_t   wdata;
  logic       branch_decision;

  ex_decode u_decode (
    .en_i        (en_i),
    .op_i        (req_i.op),
    .alu_ctrl_o  (alu_ctrl),
    .mult_ctrl_o (mult_ctrl),
    .unit_o      (unit)
  );

  ex_alu u_alu (
    .ctrl_i         (alu_ctrl),
    .operand_a_i    (req_i.operand_a),
    .operand_b_i    (req_i.operand_b),
    .result_o       (alu_result),
    .adder_result_o (adder_result),
    .cmp_result_o   (cmp_result)
  );

  // Operands stay on the request for the whole multiply
  ex_mult u_mult (
    .clk         (clk),
    .rst_i       (rst_i),
    .ctrl_i      (mult_ctrl),
    .operand_a_i (req_i.operand_a),
    .operand_b_i (req_i.operand_b),
    .result_o    (mult_result),
    .done_o      (mult_done)
  );

  ex_result u_result (
    .unit_i            (unit),
    .alu_result_i      (alu_result),
    .mult_result_i     (mult_result),
    .cmp_result_i      (cmp_result),
    .mult_done_i       (mult_done),
    .lsu_ready_i       (lsu_ready_i),
    .wdata_o           (wdata),
    .branch_decision_o (branch_decision),
    .ex_ready_o        (ex_ready_o)
  );

  // Adder result doubles as jump target and LSU address
  assign rsp_o.wdata           = wdata;
  assign rsp_o.adder_result    = adder_result;
  assign rsp_o.branch_decision = branch_decision;

endmodule

/* ex_result.sv */
////////////////////////////////////////
// Result stage of execute
// Write-back select, branch decision,
// stage ready
////////////////////////////////////////

`timescale 1ns/10ps

module ex_result (
  input  ex_unit_pkg::ex_unit_e unit_i,
  input  ex_isa_pkg::ex_word_t  alu_result_i,
  input  ex_isa_pkg::ex_word_t  mult_result_i,
  input  logic                  cmp_result_i,
  input  logic                  mult_done_i,
  input  logic                  lsu_ready_i,
  output ex_isa_pkg::ex_word_t  wdata_o,
  output logic                  branch_decision_o,
  output logic                  ex_ready_o
);

  import ex_unit_pkg::*;

  // Product for multiplies, ALU result for everything else
  assign wdata_o = (unit_i == UNIT_MULT) ? mult_result_i : alu_result_i;

  // Compare bit only counts for ALU operations
  assign branch_decision_o = (unit_i == UNIT_ALU) & cmp_result_i;

  // Stall while a multiply or memory access is busy
  always_comb begin
    unique case (unit_i)
      UNIT_MULT: ex_ready_o = mult_done_i;
      UNIT_LSU:  ex_ready_o = lsu_ready_i;
      // Single-cycle ops and idle
      default:   ex_ready_o = 1'b1;
    endcase
  end

endmodule

/* ex_mult.sv */
////////////////////////////////////////
// Iterative 32x32 multiplier
// One 17x17 signed product per cycle,
// four partial products into an accumulator
////////////////////////////////////////

`timescale 1ns/10ps

module ex_mult (
  input  logic                    clk,
  input  logic                    rst_i,
  input  ex_unit_pkg::mult_ctrl_t ctrl_i,
  input  ex_isa_pkg::ex_word_t    operand_a_i,
  input  ex_isa_pkg::ex_word_t    operand_b_i,
  output ex_isa_pkg::ex_word_t    result_o,
  output logic                    done_o
);

  import ex_isa_pkg::*;
  import ex_unit_pkg::*;

  localparam int HALF = XLEN / 2;
  localparam int ACCW = 2 * XLEN + 2;

  mult_state_e state;
  mult_state_e state_nxt;
  mult_state_e pp_sel;

  logic                   a_signed;
  logic                   b_signed;
  logic signed [HALF:0]   a_lo;
  logic signed [HALF:0]   a_hi;
  logic signed [HALF:0]   b_lo;
  logic signed [HALF:0]   b_hi;
  logic signed [HALF:0]   pp_a;
  logic signed [HALF:0]   pp_b;
  logic signed [2*HALF+1:0] pp;
  logic [ACCW-1:0]        pp_ext;
  logic [ACCW-1:0]        pp_shift;
  logic [ACCW-1:0]        acc_base;
  logic [ACCW-1:0]        acc;

  ////////////////////////////////////////
  // Operand halves
  ////////////////////////////////////////

  assign a_signed = ctrl_i.signed_mode[1];
  assign b_signed = ctrl_i.signed_mode[0];

  // Low halves are always unsigned magnitudes
  assign a_lo = {1'b0, operand_a_i[HALF-1:0]};
  assign b_lo = {1'b0, operand_b_i[HALF-1:0]};
  // Upper halves carry the operand sign when signed
  assign a_hi = {a_signed & operand_a_i[XLEN-1], operand_a_i[XLEN-1:HALF]};
  assign b_hi = {b_signed & operand_b_i[XLEN-1], operand_b_i[XLEN-1:HALF]};

  // LL product is taken on the start edge while still in IDLE
  assign pp_sel = (state == IDLE) ? PP_LL : state;

  always_comb begin
    unique case (pp_sel)
      PP_LL: begin
        pp_a = a_lo;
        pp_b = b_lo;
      end
      PP_LH: begin
        pp_a = a_lo;
        pp_b = b_hi;
      end
      PP_HL: begin
        pp_a = a_hi;
        pp_b = b_lo;
      end
      PP_HH: begin
        pp_a = a_hi;
        pp_b = b_hi;
      end
      default: begin
        pp_a = '0;
        pp_b = '0;
      end
    endcase
  end

  // The single 17x17 signed multiplier
  assign pp     = pp_a * pp_b;
  assign pp_ext = {{(ACCW-2*HALF-2){pp[2*HALF+1]}}, pp};

  // Weight of the partial product in the full result
  always_comb begin
    unique case (pp_sel)
      PP_LH, PP_HL: pp_shift = pp_ext << HALF;
      PP_HH:        pp_shift = pp_ext << XLEN;
      default:      pp_shift = pp_ext;
    endcase
  end

  ////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////

  // A new multiply starts from zero
  assign acc_base = (state == IDLE) ? '0 : acc;

  always_ff @(posedge clk) begin
    if (state != DONE) begin
      acc <= acc_base + pp_shift;
    end
  end

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_comb begin
    unique case (state)
      IDLE:    state_nxt = ctrl_i.en ? PP_LH : IDLE;
      PP_LH:   state_nxt = PP_HL;
      PP_HL:   state_nxt = PP_HH;
      PP_HH:   state_nxt = DONE;
      // One-cycle result, then back for the next request
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Product word, valid while done is high
  assign result_o = (ctrl_i.op == MULT_HIGH) ? acc[2*XLEN-1:XLEN] : acc[XLEN-1:0];
  assign done_o   = (state == DONE);

endmodule

/* ex_alu.sv */
////////////////////////////////////////
// Single-cycle ALU
// Shared adder for add, sub and compares,
// logic ops, barrel shifter, comparator
////////////////////////////////////////

`timescale 1ns/10ps

module ex_alu (
  input  ex_unit_pkg::alu_ctrl_t ctrl_i,
  input  ex_isa_pkg::ex_word_t   operand_a_i,
  input  ex_isa_pkg::ex_word_t   operand_b_i,
  output ex_isa_pkg::ex_word_t   result_o,
  output ex_isa_pkg::ex_word_t   adder_result_o,
  output logic                   cmp_result_o
);

  import ex_isa_pkg::*;
  import ex_unit_pkg::*;

  // Bit order reversal, lets one right shifter do left shifts
  function automatic ex_word_t reverse_word(input ex_word_t w);
    ex_word_t r;
    for (int i = 0; i < XLEN; i++) begin
      r[i] = w[XLEN-1-i];
    end
    return r;
  endfunction

  ////////////////////////////////////////
  // Adder
  ////////////////////////////////////////

  logic           do_sub;
  ex_word_t       adder_b;
  logic [XLEN:0]  adder_full;
  logic           carry_out;

  // Every compare is a subtraction
  assign do_sub = ctrl_i.op inside {ALU_SUB, ALU_EQ, ALU_NE, ALU_LT,
                                    ALU_GE, ALU_LTU, ALU_GEU};

  // Two's complement: invert b and feed a carry in
  assign adder_b    = do_sub ? ~operand_b_i : operand_b_i;
  assign adder_full = {1'b0, operand_a_i} + {1'b0, adder_b} + {{XLEN{1'b0}}, do_sub};
  assign carry_out  = adder_full[XLEN];

  assign adder_result_o = adder_full[XLEN-1:0];

  ////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////

  logic is_equal;
  logic is_ltu;
  logic is_lt;

  assign is_equal = (adder_full[XLEN-1:0] == '0);
  // No carry out of a - b means a borrowed, so a < b unsigned
  assign is_ltu   = ~carry_out;
  // Differing signs decide directly, same signs match unsigned
  assign is_lt    = (operand_a_i[XLEN-1] != operand_b_i[XLEN-1]) ?
                    operand_a_i[XLEN-1] : is_ltu;

  always_comb begin
    unique case (ctrl_i.op)
      ALU_EQ:  cmp_result_o = is_equal;
      ALU_NE:  cmp_result_o = ~is_equal;
      ALU_LT:  cmp_result_o = is_lt;
      ALU_GE:  cmp_result_o = ~is_lt;
      ALU_LTU: cmp_result_o = is_ltu;
      ALU_GEU: cmp_result_o = ~is_ltu;
      default: cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////

  logic                   shift_left;
  logic [4:0]             shamt;
  ex_word_t               shift_src;
  logic signed [XLEN:0]   shift_ext;
  logic signed [XLEN:0]   shift_full;
  ex_word_t               shift_result;

  assign shift_left = (ctrl_i.op == ALU_SLL);
  assign shamt      = operand_b_i[4:0];
  assign shift_src  = shift_left ? reverse_word(operand_a_i) : operand_a_i;

  // Extra top bit is the fill, sign only for SRA
  assign shift_ext    = {(ctrl_i.op == ALU_SRA) & operand_a_i[XLEN-1], shift_src};
  assign shift_full   = shift_ext >>> shamt;
  assign shift_result = shift_left ? reverse_word(shift_full[XLEN-1:0]) :
                        shift_full[XLEN-1:0];

  ////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////

  always_comb begin
    if (ctrl_i.cmp_wb) begin
      // SLT and SLTU, comparison bit zero-extended
      result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    end else begin
      unique case (ctrl_i.op)
        ALU_AND: result_o = operand_a_i & operand_b_i;
        ALU_OR:  result_o = operand_a_i | operand_b_i;
        ALU_XOR: result_o = operand_a_i ^ operand_b_i;
        ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
        // Add, sub and branch compares give the adder result
        default: result_o = adder_full[XLEN-1:0];
      endcase
    end
  end

endmodule

/* ex_decode.sv */
////////////////////////////////////////
// Operation decoder for the execute stage
// ALU control, multiplier control and
// unit select from the external opcode
////////////////////////////////////////

`timescale 1ns/10ps

module ex_decode (
  input  logic                   en_i,
  input  ex_isa_pkg::ex_op_e     op_i,
  output ex_unit_pkg::alu_ctrl_t  alu_ctrl_o,
  output ex_unit_pkg::mult_ctrl_t mult_ctrl_o,
  output ex_unit_pkg::ex_unit_e   unit_o
);

  import ex_isa_pkg::*;
  import ex_unit_pkg::*;

  ex_unit_e unit_sel;

  always_comb begin
    // Defaults: plain add through the ALU
    alu_ctrl_o.op          = ALU_ADD;
    alu_ctrl_o.cmp_wb      = 1'b0;
    mult_ctrl_o.op         = MULT_LOW;
    mult_ctrl_o.signed_mode = 2'b00;
    unit_sel               = UNIT_ALU;

    unique case (op_i)
      OP_ADD:  alu_ctrl_o.op = ALU_ADD;
      OP_SUB:  alu_ctrl_o.op = ALU_SUB;
      OP_AND:  alu_ctrl_o.op = ALU_AND;
      OP_OR:   alu_ctrl_o.op = ALU_OR;
      OP_XOR:  alu_ctrl_o.op = ALU_XOR;
      OP_SLL:  alu_ctrl_o.op = ALU_SLL;
      OP_SRL:  alu_ctrl_o.op = ALU_SRL;
      OP_SRA:  alu_ctrl_o.op = ALU_SRA;
      // Set-less-than writes the comparison bit back
      OP_SLT: begin
        alu_ctrl_o.op     = ALU_LT;
        alu_ctrl_o.cmp_wb = 1'b1;
      end
      OP_SLTU: begin
        alu_ctrl_o.op     = ALU_LTU;
        alu_ctrl_o.cmp_wb = 1'b1;
      end
      // Branches only drive the decision
      OP_BEQ:  alu_ctrl_o.op = ALU_EQ;
      OP_BNE:  alu_ctrl_o.op = ALU_NE;
      OP_BLT:  alu_ctrl_o.op = ALU_LT;
      OP_BGE:  alu_ctrl_o.op = ALU_GE;
      OP_BLTU: alu_ctrl_o.op = ALU_LTU;
      OP_BGEU: alu_ctrl_o.op = ALU_GEU;
      // Low word is the same for any signedness
      OP_MUL:  unit_sel = UNIT_MULT;
      OP_MULH: begin
        unit_sel                = UNIT_MULT;
        mult_ctrl_o.op          = MULT_HIGH;
        mult_ctrl_o.signed_mode = 2'b11;
      end
      OP_MULHSU: begin
        unit_sel                = UNIT_MULT;
        mult_ctrl_o.op          = MULT_HIGH;
        mult_ctrl_o.signed_mode = 2'b10;
      end
      OP_MULHU: begin
        unit_sel       = UNIT_MULT;
        mult_ctrl_o.op = MULT_HIGH;
      end
      // Address is the adder result, LSU decides the latency
      OP_LSU_ADDR: unit_sel = UNIT_LSU;
      default: unit_sel = UNIT_ALU;
    endcase
  end

  // Idle cycles look like a one-cycle ALU operation
  assign unit_o = en_i ? unit_sel : UNIT_ALU;

  // Multiplier only starts on a valid request
  assign mult_ctrl_o.en = en_i && (unit_sel == UNIT_MULT);

endmodule

/* ex_unit_pkg.sv */
////////////////////////////////////////
// Internal unit control
// ALU and multiplier opcodes, multiplier
// states, unit select, control bundles
////////////////////////////////////////

package ex_unit_pkg;

  // Cycles from multiply start to ready
  localparam int MULT_CYCLES = 4;

  // ALU operations, SLT and BLT share ALU_LT
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Low word, or high word with signs from the signed mode
  typedef enum logic {
    MULT_LOW,
    MULT_HIGH
  } mult_op_e;

  // Multiplier sequence, one partial product per state
  typedef enum logic [2:0] {
    IDLE, PP_LL, PP_LH, PP_HL, PP_HH, DONE
  } mult_state_e;

  // Which unit owns the current operation
  typedef enum logic [1:0] {
    UNIT_ALU, UNIT_MULT, UNIT_LSU
  } ex_unit_e;

  typedef struct packed {
    alu_op_e op;
    // Result is the comparison bit (SLT, SLTU)
    logic    cmp_wb;
  } alu_ctrl_t;

  typedef struct packed {
    logic       en;
    mult_op_e   op;
    // Bit 1 operand a signed, bit 0 operand b signed
    logic [1:0] signed_mode;
  } mult_ctrl_t;

endpackage

/* ex_isa_pkg.sv */
////////////////////////////////////////
// Execute stage view of the ISA
// Data word, operation codes from decode,
// request and response bundles
////////////////////////////////////////

package ex_isa_pkg;

  // Data path width
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] ex_word_t;

  // Operations as delivered by the decode stage
  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA,
    OP_SLT, OP_SLTU,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
    OP_LSU_ADDR
  } ex_op_e;

  // Request from decode, 69 bits
  typedef struct packed {
    ex_op_e   op;
    ex_word_t operand_a;
    ex_word_t operand_b;
  } ex_req_t;

  // Response to write-back, fetch and LSU, 65 bits
  typedef struct packed {
    ex_word_t wdata;
    ex_word_t adder_result;
    logic     branch_decision;
  } ex_rsp_t;

endpackage
